// File: logic/fetch_slicer.sv
// fetch packet register with no back-pressure; base PC must be word aligned while i_valid is high
`timescale 1ns/1ps
`default_nettype none

module fetch_slicer #(
  parameter int LANES = 2
) (
  input  logic                              i_clk,
  input  logic                              i_rst_n,
  input  logic                              i_valid,
  input  logic [LANES*32-1:0]               i_packet,
  input  logic [rv_isa_pkg::XLEN-1:0]       i_pc,
  output logic                              o_valid,
  output logic [LANES*32-1:0]               o_inst,
  output logic [LANES*rv_isa_pkg::XLEN-1:0] o_pc
);

  import rv_isa_pkg::*;

  logic [LANES*XLEN-1:0] lane_pc;

  // lane k sits 4*k bytes above the base
  for (genvar k = 0; k < LANES; k++) begin : g_lane_pc
    assign lane_pc[k*XLEN +: XLEN] = i_pc + XLEN'(4 * k);
  end

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      o_valid <= 1'b0;
    end else begin
      o_valid <= i_valid;
    end
  end

  // payload held while no packet arrives
  always_ff @(posedge i_clk) begin
    if (i_valid) begin
      o_inst <= i_packet;
      o_pc   <= lane_pc;
    end
  end

  a_pc_aligned: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_valid |-> (i_pc[1:0] == 2'b00))
    else $error("fetch base pc %h not word aligned", i_pc);

endmodule

`default_nettype wire

// File: logic/issue_stage.sv
// registers decoded lanes; halt and hazards are only reported and nothing downstream stalls
`timescale 1ns/1ps
`default_nettype none

module issue_stage #(
  parameter int LANES = 2
) (
  input  logic                                          i_clk,
  input  logic                                          i_rst_n,
  input  logic                                          i_valid,
  input  logic [LANES*rv_isa_pkg::XLEN-1:0]             i_pc,
  input  logic [LANES*rv_isa_pkg::XLEN-1:0]             i_imm,
  input  logic [LANES*5-1:0]                            i_ra,
  input  logic [LANES*5-1:0]                            i_rb,
  input  logic [LANES*5-1:0]                            i_rd,
  input  logic [LANES-1:0]                              i_reg_wr,
  input  logic [LANES-1:0]                              i_alu_a_src,
  input  logic [LANES*rv_ctrl_pkg::ALU_B_SRC_W-1:0]     i_alu_b_src,
  input  logic [LANES*rv_ctrl_pkg::ALU_CTR_W-1:0]       i_alu_ctr,
  input  logic [LANES-1:0]                              i_pc_a_src,
  input  logic [LANES-1:0]                              i_pc_b_src,
  input  logic [LANES-1:0]                              i_mem_to_reg,
  input  logic [LANES-1:0]                              i_mem_wr,
  input  logic [LANES*rv_ctrl_pkg::MEM_OP_W-1:0]        i_mem_op,
  input  logic [LANES-1:0]                              i_is_break,
  input  logic [LANES-1:0]                              i_illegal,
  output logic [LANES-1:0]                              o_lane_valid,
  output logic [LANES-1:0]                              o_raw_hazard,
  output logic [LANES-1:0]                              o_illegal,
  output logic                                          o_halt,
  output logic [LANES*rv_isa_pkg::XLEN-1:0]             o_pc,
  output logic [LANES*rv_isa_pkg::XLEN-1:0]             o_imm,
  output logic [LANES*5-1:0]                            o_rd,
  output logic [LANES*5-1:0]                            o_ra,
  output logic [LANES*5-1:0]                            o_rb,
  output logic [LANES-1:0]                              o_reg_wr,
  output logic [LANES-1:0]                              o_alu_a_src,
  output logic [LANES*rv_ctrl_pkg::ALU_B_SRC_W-1:0]     o_alu_b_src,
  output logic [LANES*rv_ctrl_pkg::ALU_CTR_W-1:0]       o_alu_ctr,
  output logic [LANES-1:0]                              o_pc_a_src,
  output logic [LANES-1:0]                              o_pc_b_src,
  output logic [LANES-1:0]                              o_mem_to_reg,
  output logic [LANES-1:0]                              o_mem_wr,
  output logic [LANES*rv_ctrl_pkg::MEM_OP_W-1:0]        o_mem_op
);

  logic [LANES-1:0] lane_vld;
  logic [LANES:0]   brk_below;  // valid ebreak somewhere in a lower lane
  logic [LANES-1:0] wr_live;
  logic [LANES-1:0] hazard;

  assign brk_below[0] = 1'b0;

  // prefix scan from lane 0 upward
  for (genvar k = 0; k < LANES; k++) begin : g_scan
    assign lane_vld[k]    = i_valid & ~brk_below[k];
    assign brk_below[k+1] = brk_below[k] | (lane_vld[k] & i_is_break[k]);
    assign wr_live[k]     = lane_vld[k] & i_reg_wr[k] & (|i_rd[k*5 +: 5]);  // x0 never counts
  end

  always_comb begin
    hazard = '0;
    for (int k = 1; k < LANES; k++) begin
      for (int j = 0; j < k; j++) begin
        if (lane_vld[k] && wr_live[j] &&
            (i_rd[j*5 +: 5] == i_ra[k*5 +: 5] || i_rd[j*5 +: 5] == i_rb[k*5 +: 5]))
          hazard[k] = 1'b1;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      o_lane_valid <= '0;
      o_raw_hazard <= '0;
      o_illegal    <= '0;
      o_halt       <= 1'b0;
    end else begin
      o_lane_valid <= lane_vld;
      o_raw_hazard <= hazard;
      o_illegal    <= lane_vld & i_illegal;
      o_halt       <= brk_below[LANES];
    end
  end

  always_ff @(posedge i_clk) begin
    o_pc         <= i_pc;
    o_imm        <= i_imm;
    o_rd         <= i_rd;
    o_ra         <= i_ra;
    o_rb         <= i_rb;
    o_reg_wr     <= i_reg_wr;
    o_alu_a_src  <= i_alu_a_src;
    o_alu_b_src  <= i_alu_b_src;
    o_alu_ctr    <= i_alu_ctr;
    o_pc_a_src   <= i_pc_a_src;
    o_pc_b_src   <= i_pc_b_src;
    o_mem_to_reg <= i_mem_to_reg;
    o_mem_wr     <= i_mem_wr;
    o_mem_op     <= i_mem_op;
  end

  for (genvar k = 1; k < LANES; k++) begin : g_chk_mask
    a_masked_after_break: assert property (@(posedge i_clk) disable iff (!i_rst_n)
      |(i_is_break[k-1:0] & lane_vld[k-1:0]) |=> !o_lane_valid[k])
      else $error("lane %0d issued after ebreak", k);
  end

  a_halt_with_lane: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    o_halt |-> |o_lane_valid)
    else $error("halt raised with no valid lane");

endmodule

`default_nettype wire

// File: logic/rv_ctrl_pkg.sv
// datapath control encodings shared by decoder and issue logic, codes beyond these are unused
`default_nettype none

package rv_ctrl_pkg;

  localparam int ALU_CTR_W   = 4;
  localparam int MEM_OP_W    = 3;
  localparam int ALU_B_SRC_W = 2;
  localparam int EXT_W       = 3;

  // alu operation
  localparam logic [ALU_CTR_W-1:0] ALU_ADD    = 4'd0;
  localparam logic [ALU_CTR_W-1:0] ALU_COPY_B = 4'd3;   // pass operand b through
  localparam logic [ALU_CTR_W-1:0] ALU_BREAK  = 4'd14;
  localparam logic [ALU_CTR_W-1:0] ALU_NONE   = 4'd15;

  // memory access type
  localparam logic [MEM_OP_W-1:0] MEM_SW   = 3'd4;  // signed word
  localparam logic [MEM_OP_W-1:0] MEM_SD   = 3'd6;  // doubleword
  localparam logic [MEM_OP_W-1:0] MEM_NONE = 3'd7;

  // immediate layout selector
  localparam logic [EXT_W-1:0] EXT_I = 3'd0;
  localparam logic [EXT_W-1:0] EXT_U = 3'd1;
  localparam logic [EXT_W-1:0] EXT_S = 3'd2;
  localparam logic [EXT_W-1:0] EXT_B = 3'd3;
  localparam logic [EXT_W-1:0] EXT_J = 3'd4;

endpackage

`default_nettype wire

// File: logic/rv_decode_top.sv
// multi-lane decode with fixed 2-cycle latency and no ready; a packet is taken whenever i_valid
`timescale 1ns/1ps
`default_nettype none

module rv_decode_top #(
  parameter int LANES = 2
) (
  input  logic                                      i_clk,
  input  logic                                      i_rst_n,
  input  logic                                      i_valid,
  input  logic [LANES*32-1:0]                       i_packet,
  input  logic [rv_isa_pkg::XLEN-1:0]               i_pc,
  output logic [LANES-1:0]                          o_lane_valid,
  output logic [LANES-1:0]                          o_raw_hazard,
  output logic [LANES-1:0]                          o_illegal,
  output logic                                      o_halt,
  output logic [LANES*rv_isa_pkg::XLEN-1:0]         o_pc,
  output logic [LANES*rv_isa_pkg::XLEN-1:0]         o_imm,
  output logic [LANES*5-1:0]                        o_rd,
  output logic [LANES*5-1:0]                        o_ra,
  output logic [LANES*5-1:0]                        o_rb,
  output logic [LANES-1:0]                          o_reg_wr,
  output logic [LANES-1:0]                          o_alu_a_src,
  output logic [LANES*rv_ctrl_pkg::ALU_B_SRC_W-1:0] o_alu_b_src,
  output logic [LANES*rv_ctrl_pkg::ALU_CTR_W-1:0]   o_alu_ctr,
  output logic [LANES-1:0]                          o_pc_a_src,
  output logic [LANES-1:0]                          o_pc_b_src,
  output logic [LANES-1:0]                          o_mem_to_reg,
  output logic [LANES-1:0]                          o_mem_wr,
  output logic [LANES*rv_ctrl_pkg::MEM_OP_W-1:0]    o_mem_op
);

  import rv_isa_pkg::*;
  import rv_ctrl_pkg::*;

  logic                         s_valid;
  logic [LANES*32-1:0]          s_inst;
  logic [LANES*XLEN-1:0]        s_pc;
  logic [LANES*XLEN-1:0]        imm;
  logic [LANES*5-1:0]           ra;
  logic [LANES*5-1:0]           rb;
  logic [LANES*5-1:0]           rd;
  logic [LANES-1:0]             reg_wr;
  logic [LANES-1:0]             alu_a_src;
  logic [LANES*ALU_B_SRC_W-1:0] alu_b_src;
  logic [LANES*ALU_CTR_W-1:0]   alu_ctr;
  logic [LANES-1:0]             pc_a_src;
  logic [LANES-1:0]             pc_b_src;
  logic [LANES-1:0]             mem_to_reg;
  logic [LANES-1:0]             mem_wr;
  logic [LANES*MEM_OP_W-1:0]    mem_op;
  logic [LANES-1:0]             is_break;
  logic [LANES-1:0]             illegal;

  fetch_slicer #(.LANES(LANES)) u_slicer (
    .i_clk    (i_clk),
    .i_rst_n  (i_rst_n),
    .i_valid  (i_valid),
    .i_packet (i_packet),
    .i_pc     (i_pc),
    .o_valid  (s_valid),
    .o_inst   (s_inst),
    .o_pc     (s_pc)
  );

  // one decoder per lane
  for (genvar k = 0; k < LANES; k++) begin : g_lane
    rv_idu u_idu (
      .i_inst       (s_inst[k*32 +: 32]),
      .o_imm        (imm[k*XLEN +: XLEN]),
      .o_ra         (ra[k*5 +: 5]),
      .o_rb         (rb[k*5 +: 5]),
      .o_rd         (rd[k*5 +: 5]),
      .o_reg_wr     (reg_wr[k]),
      .o_alu_a_src  (alu_a_src[k]),
      .o_alu_b_src  (alu_b_src[k*ALU_B_SRC_W +: ALU_B_SRC_W]),
      .o_alu_ctr    (alu_ctr[k*ALU_CTR_W +: ALU_CTR_W]),
      .o_pc_a_src   (pc_a_src[k]),
      .o_pc_b_src   (pc_b_src[k]),
      .o_mem_to_reg (mem_to_reg[k]),
      .o_mem_wr     (mem_wr[k]),
      .o_mem_op     (mem_op[k*MEM_OP_W +: MEM_OP_W]),
      .o_is_break   (is_break[k]),
      .o_illegal    (illegal[k])
    );
  end

  issue_stage #(.LANES(LANES)) u_issue (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .i_valid      (s_valid),
    .i_pc         (s_pc),
    .i_imm        (imm),
    .i_ra         (ra),
    .i_rb         (rb),
    .i_rd         (rd),
    .i_reg_wr     (reg_wr),
    .i_alu_a_src  (alu_a_src),
    .i_alu_b_src  (alu_b_src),
    .i_alu_ctr    (alu_ctr),
    .i_pc_a_src   (pc_a_src),
    .i_pc_b_src   (pc_b_src),
    .i_mem_to_reg (mem_to_reg),
    .i_mem_wr     (mem_wr),
    .i_mem_op     (mem_op),
    .i_is_break   (is_break),
    .i_illegal    (illegal),
    .o_lane_valid (o_lane_valid),
    .o_raw_hazard (o_raw_hazard),
    .o_illegal    (o_illegal),
    .o_halt       (o_halt),
    .o_pc         (o_pc),
    .o_imm        (o_imm),
    .o_rd         (o_rd),
    .o_ra         (o_ra),
    .o_rb         (o_rb),
    .o_reg_wr     (o_reg_wr),
    .o_alu_a_src  (o_alu_a_src),
    .o_alu_b_src  (o_alu_b_src),
    .o_alu_ctr    (o_alu_ctr),
    .o_pc_a_src   (o_pc_a_src),
    .o_pc_b_src   (o_pc_b_src),
    .o_mem_to_reg (o_mem_to_reg),
    .o_mem_wr     (o_mem_wr),
    .o_mem_op     (o_mem_op)
  );

endmodule

`default_nettype wire

// File: logic/rv_idu.sv
// combinational decoder for nine RV64I instructions and any other word is flagged illegal
`timescale 1ns/1ps
`default_nettype none

module rv_idu (
  input  rv_isa_pkg::rv_inst_u                 i_inst,
  output logic [rv_isa_pkg::XLEN-1:0]          o_imm,
  output logic [4:0]                           o_ra,
  output logic [4:0]                           o_rb,
  output logic [4:0]                           o_rd,
  output logic                                 o_reg_wr,
  output logic                                 o_alu_a_src,
  output logic [rv_ctrl_pkg::ALU_B_SRC_W-1:0]  o_alu_b_src,
  output logic [rv_ctrl_pkg::ALU_CTR_W-1:0]    o_alu_ctr,
  output logic                                 o_pc_a_src,
  output logic                                 o_pc_b_src,
  output logic                                 o_mem_to_reg,
  output logic                                 o_mem_wr,
  output logic [rv_ctrl_pkg::MEM_OP_W-1:0]     o_mem_op,
  output logic                                 o_is_break,
  output logic                                 o_illegal
);

  import rv_isa_pkg::*;
  import rv_ctrl_pkg::*;

  logic [31:0]      w;
  logic [6:0]       opcode;
  logic [2:0]       funct3;
  logic [XLEN-1:0]  imm_i;
  logic [XLEN-1:0]  imm_u;
  logic [XLEN-1:0]  imm_s;
  logic [XLEN-1:0]  imm_b;
  logic [XLEN-1:0]  imm_j;
  logic             inst_lui;
  logic             inst_auipc;
  logic             inst_jal;
  logic             inst_jalr;
  logic             inst_lw;
  logic             inst_sw;
  logic             inst_addi;
  logic             inst_ebreak;
  logic             inst_sd;
  logic             type_i;
  logic             type_u;
  logic             type_s;
  logic             type_j;
  logic             alu_copy;
  logic             alu_plus;
  logic [EXT_W-1:0] ext_op;

  assign w      = i_inst;
  assign opcode = i_inst.ifmt.opcode;
  assign funct3 = i_inst.ifmt.funct3;

  assign o_ra = i_inst.ifmt.rs1;
  assign o_rb = i_inst.sfmt.rs2;
  assign o_rd = i_inst.ifmt.rd;

  // immediate candidates sign extended from bit 31
  assign imm_i = {{(XLEN-12){w[31]}}, i_inst.ifmt.imm_11_0};
  assign imm_s = {{(XLEN-12){w[31]}}, i_inst.sfmt.imm_11_5, i_inst.sfmt.imm_4_0};
  assign imm_u = {{(XLEN-32){w[31]}}, w[31:12], 12'b0};
  assign imm_b = {{(XLEN-12){w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
  assign imm_j = {{(XLEN-20){w[31]}}, w[19:12], w[20], w[30:21], 1'b0};

  assign inst_lui    = (opcode == OP_LUI);
  assign inst_auipc  = (opcode == OP_AUIPC);
  assign inst_jal    = (opcode == OP_JAL);
  assign inst_jalr   = (opcode == OP_JALR) && (funct3 == F3_ZERO);
  assign inst_lw     = (opcode == OP_LOAD) && (funct3 == F3_W);
  assign inst_sw     = (opcode == OP_STORE) && (funct3 == F3_W);
  assign inst_addi   = (opcode == OP_IMM) && (funct3 == F3_ZERO);
  assign inst_ebreak = (opcode == OP_SYSTEM) && (funct3 == F3_ZERO);  // imm field not checked
  assign inst_sd     = (opcode == OP_STORE) && (funct3 == F3_D);

  assign type_i = inst_lw | inst_addi | inst_ebreak | inst_jalr;
  assign type_u = inst_lui | inst_auipc;
  assign type_s = inst_sw | inst_sd;
  assign type_j = inst_jal;

  always_comb begin
    ext_op = EXT_I;  // unknown words fall back to I layout
    if (type_u) ext_op = EXT_U;
    else if (type_s) ext_op = EXT_S;
    else if (type_j) ext_op = EXT_J;
  end

  always_comb begin
    case (ext_op)
      EXT_U:   o_imm = imm_u;
      EXT_S:   o_imm = imm_s;
      EXT_B:   o_imm = imm_b;  // no branch decode yet
      EXT_J:   o_imm = imm_j;
      default: o_imm = imm_i;
    endcase
  end

  assign o_reg_wr     = type_i | type_u | type_j;
  assign o_alu_a_src  = inst_jal | inst_auipc | inst_jalr;  // pc feeds operand a
  assign o_alu_b_src  = {inst_jal | inst_jalr, (type_i | type_u | type_s) & ~inst_jalr};
  assign o_pc_a_src   = inst_jal | inst_jalr;
  assign o_pc_b_src   = inst_jalr;
  assign o_mem_to_reg = inst_lw;
  assign o_mem_wr     = type_s;
  assign o_is_break   = inst_ebreak;
  assign o_illegal    = ~(type_i | type_u | type_s | type_j);

  assign alu_copy = inst_lui;
  assign alu_plus = inst_auipc | inst_jal | inst_jalr | inst_sw | inst_addi | inst_sd;

  always_comb begin
    if (inst_lw || inst_sw) o_mem_op = MEM_SW;
    else if (inst_sd) o_mem_op = MEM_SD;
    else o_mem_op = MEM_NONE;
  end

  // lw keeps ALU_NONE since the address add lives in the load path
  always_comb begin
    if (alu_copy) o_alu_ctr = ALU_COPY_B;
    else if (alu_plus) o_alu_ctr = ALU_ADD;
    else if (inst_ebreak) o_alu_ctr = ALU_BREAK;
    else o_alu_ctr = ALU_NONE;
  end

endmodule

`default_nettype wire

// File: logic/rv_isa_pkg.sv
// RV64 base ISA definitions for the decoded subset only, with no compressed or R/B-type encodings
`default_nettype none

package rv_isa_pkg;

  localparam int XLEN = 64;

  // major opcodes
  localparam logic [6:0] OP_LUI    = 7'b0110111;
  localparam logic [6:0] OP_AUIPC  = 7'b0010111;
  localparam logic [6:0] OP_JAL    = 7'b1101111;
  localparam logic [6:0] OP_JALR   = 7'b1100111;
  localparam logic [6:0] OP_LOAD   = 7'b0000011;
  localparam logic [6:0] OP_STORE  = 7'b0100011;
  localparam logic [6:0] OP_IMM    = 7'b0010011;
  localparam logic [6:0] OP_SYSTEM = 7'b1110011;

  localparam logic [2:0] F3_W    = 3'b010;  // word access
  localparam logic [2:0] F3_D    = 3'b011;  // doubleword access
  localparam logic [2:0] F3_ZERO = 3'b000;

  // I layout, also used by jalr and ebreak
  typedef struct packed {
    logic [11:0] imm_11_0;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } rv_inst_i_t;

  // S layout, immediate split around rs2/rs1
  typedef struct packed {
    logic [6:0] imm_11_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_4_0;
    logic [6:0] opcode;
  } rv_inst_s_t;

  // same 32-bit word seen through either layout
  typedef union packed {
    rv_inst_i_t ifmt;
    rv_inst_s_t sfmt;
  } rv_inst_u;

endpackage

`default_nettype wire

// File: rv_decode.f
+incdir+verif
logic/rv_isa_pkg.sv
logic/rv_ctrl_pkg.sv
logic/fetch_slicer.sv
logic/rv_idu.sv
logic/issue_stage.sv
logic/rv_decode_top.sv
verif/tb_rv_decode.sv

// File: verif/decode_model.svh
// reference decode model; include inside the testbench module after both package imports and LANES
`ifndef DECODE_MODEL_SVH
`define DECODE_MODEL_SVH

typedef struct packed {
  logic [XLEN-1:0]        imm;
  logic [4:0]             ra;
  logic [4:0]             rb;
  logic [4:0]             rd;
  logic                   reg_wr;
  logic                   alu_a_src;
  logic [ALU_B_SRC_W-1:0] alu_b_src;
  logic [ALU_CTR_W-1:0]   alu_ctr;
  logic                   pc_a_src;
  logic                   pc_b_src;
  logic                   mem_to_reg;
  logic                   mem_wr;
  logic [MEM_OP_W-1:0]    mem_op;
  logic                   is_break;
  logic                   illegal;
} lane_dec_t;

// immediates by format, sign taken from the top bit of each field
function automatic logic [XLEN-1:0] imm_i(input logic [31:0] w);
  logic signed [XLEN-1:0] v;
  v = $signed(w[31:20]);
  return v;
endfunction

function automatic logic [XLEN-1:0] imm_u(input logic [31:0] w);
  logic signed [XLEN-1:0] v;
  v = $signed({w[31:12], 12'h000});
  return v;
endfunction

function automatic logic [XLEN-1:0] imm_s(input logic [31:0] w);
  logic signed [XLEN-1:0] v;
  v = $signed({w[31:25], w[11:7]});
  return v;
endfunction

function automatic logic [XLEN-1:0] imm_j(input logic [31:0] w);
  logic signed [XLEN-1:0] v;
  v = $signed({w[31], w[19:12], w[20], w[30:21], 1'b0});
  return v;
endfunction

// one row of the control table
function automatic lane_dec_t with_ctrl(input lane_dec_t d, input logic [XLEN-1:0] imm,
    input int wr, input int a_src, input int b_src, input logic [ALU_CTR_W-1:0] alu,
    input int pc_a, input int pc_b, input int m2r, input int m_wr,
    input logic [MEM_OP_W-1:0] m_op);
  d.imm        = imm;
  d.reg_wr     = wr[0];
  d.alu_a_src  = a_src[0];
  d.alu_b_src  = b_src[ALU_B_SRC_W-1:0];
  d.alu_ctr    = alu;
  d.pc_a_src   = pc_a[0];
  d.pc_b_src   = pc_b[0];
  d.mem_to_reg = m2r[0];
  d.mem_wr     = m_wr[0];
  d.mem_op     = m_op;
  d.illegal    = 1'b0;
  return d;
endfunction

function automatic lane_dec_t decode_word(input logic [31:0] w);
  lane_dec_t  d;
  logic [2:0] f3;
  f3        = w[14:12];
  d         = '0;
  d.ra      = w[19:15];
  d.rb      = w[24:20];
  d.rd      = w[11:7];
  d.imm     = imm_i(w);  // unknown words keep the I immediate
  d.alu_ctr = ALU_NONE;
  d.mem_op  = MEM_NONE;
  d.illegal = 1'b1;
  case (w[6:0])
    OP_LUI:   d = with_ctrl(d, imm_u(w), 1, 0, 1, ALU_COPY_B, 0, 0, 0, 0, MEM_NONE);
    OP_AUIPC: d = with_ctrl(d, imm_u(w), 1, 1, 1, ALU_ADD, 0, 0, 0, 0, MEM_NONE);
    OP_JAL:   d = with_ctrl(d, imm_j(w), 1, 1, 2, ALU_ADD, 1, 0, 0, 0, MEM_NONE);
    OP_JALR:
      if (f3 == F3_ZERO) d = with_ctrl(d, imm_i(w), 1, 1, 2, ALU_ADD, 1, 1, 0, 0, MEM_NONE);
    OP_LOAD:
      if (f3 == F3_W) d = with_ctrl(d, imm_i(w), 1, 0, 1, ALU_NONE, 0, 0, 1, 0, MEM_SW);
    OP_STORE:
      if (f3 == F3_W) d = with_ctrl(d, imm_s(w), 0, 0, 1, ALU_ADD, 0, 0, 0, 1, MEM_SW);
      else if (f3 == F3_D) d = with_ctrl(d, imm_s(w), 0, 0, 1, ALU_ADD, 0, 0, 0, 1, MEM_SD);
    OP_IMM:
      if (f3 == F3_ZERO) d = with_ctrl(d, imm_i(w), 1, 0, 1, ALU_ADD, 0, 0, 0, 0, MEM_NONE);
    OP_SYSTEM:
      if (f3 == F3_ZERO) begin
        d = with_ctrl(d, imm_i(w), 1, 0, 1, ALU_BREAK, 0, 0, 0, 0, MEM_NONE);
        d.is_break = 1'b1;
      end
    default: ;
  endcase
  return d;
endfunction

// {halt, hazard, lane valid} for one packet
function automatic logic [2*LANES:0] packet_flags(input logic v, input logic [LANES*32-1:0] pkt);
  lane_dec_t        dj;
  lane_dec_t        dk;
  logic [LANES-1:0] vld;
  logic [LANES-1:0] haz;
  logic             halt;
  halt = 1'b0;
  vld  = '0;
  haz  = '0;
  for (int k = 0; k < LANES; k++) begin
    vld[k] = v && !halt;  // the ebreak lane itself stays valid
    dk = decode_word(pkt[k*32 +: 32]);
    if (vld[k] && dk.is_break) halt = 1'b1;
  end
  for (int k = 1; k < LANES; k++) begin
    dk = decode_word(pkt[k*32 +: 32]);
    for (int j = 0; j < k; j++) begin
      dj = decode_word(pkt[j*32 +: 32]);
      if (vld[k] && vld[j] && dj.reg_wr && dj.rd != 5'd0 && (dj.rd == dk.ra || dj.rd == dk.rb))
        haz[k] = 1'b1;
    end
  end
  return {halt, haz, vld};
endfunction

`endif

// File: verif/tb_rv_decode.sv
// runs with LANES = 2 only; outputs are checked exactly 2 cycles after each driven packet
`timescale 1ns/1ps
`default_nettype none

module tb_rv_decode;

  import rv_isa_pkg::*;
  import rv_ctrl_pkg::*;

  localparam int LANES       = 2;
  localparam int CLK_PERIOD  = 20;
  localparam int RST_CYCLES  = 16;
  localparam int N_RANDOM    = 400;
  localparam int N_PACKETS   = N_RANDOM + 40;  // directed and idle cycles on top
  localparam int WATCHDOG_NS = N_PACKETS * 3 * CLK_PERIOD + RST_CYCLES * CLK_PERIOD;
  localparam logic [31:0] EBREAK = 32'h0010_0073;

  `include "decode_model.svh"

  typedef struct packed {
    logic                v;
    logic [XLEN-1:0]     pc;
    logic [LANES*32-1:0] pkt;
  } pkt_rec_t;

  logic                         i_clk;
  logic                         i_rst_n;
  logic                         i_valid;
  logic [LANES*32-1:0]          i_packet;
  logic [XLEN-1:0]              i_pc;
  logic [LANES-1:0]             o_lane_valid;
  logic [LANES-1:0]             o_raw_hazard;
  logic [LANES-1:0]             o_illegal;
  logic                         o_halt;
  logic [LANES*XLEN-1:0]        o_pc;
  logic [LANES*XLEN-1:0]        o_imm;
  logic [LANES*5-1:0]           o_rd;
  logic [LANES*5-1:0]           o_ra;
  logic [LANES*5-1:0]           o_rb;
  logic [LANES-1:0]             o_reg_wr;
  logic [LANES-1:0]             o_alu_a_src;
  logic [LANES*ALU_B_SRC_W-1:0] o_alu_b_src;
  logic [LANES*ALU_CTR_W-1:0]   o_alu_ctr;
  logic [LANES-1:0]             o_pc_a_src;
  logic [LANES-1:0]             o_pc_b_src;
  logic [LANES-1:0]             o_mem_to_reg;
  logic [LANES-1:0]             o_mem_wr;
  logic [LANES*MEM_OP_W-1:0]    o_mem_op;

  pkt_rec_t sent_q[$];  // packets still in the pipe
  integer   seed;
  int       n_checks;
  int       n_errors;
  int       err_mark;
  int       tests_passed;
  int       tests_failed;

  rv_decode_top #(.LANES(LANES)) i_rv_decode_top (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .i_valid      (i_valid),
    .i_packet     (i_packet),
    .i_pc         (i_pc),
    .o_lane_valid (o_lane_valid),
    .o_raw_hazard (o_raw_hazard),
    .o_illegal    (o_illegal),
    .o_halt       (o_halt),
    .o_pc         (o_pc),
    .o_imm        (o_imm),
    .o_rd         (o_rd),
    .o_ra         (o_ra),
    .o_rb         (o_rb),
    .o_reg_wr     (o_reg_wr),
    .o_alu_a_src  (o_alu_a_src),
    .o_alu_b_src  (o_alu_b_src),
    .o_alu_ctr    (o_alu_ctr),
    .o_pc_a_src   (o_pc_a_src),
    .o_pc_b_src   (o_pc_b_src),
    .o_mem_to_reg (o_mem_to_reg),
    .o_mem_wr     (o_mem_wr),
    .o_mem_op     (o_mem_op)
  );

  initial begin
    i_clk = 1'b0;
    forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
  end

  task automatic check_val(input string name, input logic [XLEN-1:0] exp,
      input logic [XLEN-1:0] act);
    n_checks++;
    assert (act === exp)
      else begin
        $display("[ERROR] %s expected %h got %h", name, exp, act);
        n_errors++;
      end
  endtask

  task automatic check_idle();
    check_val("o_lane_valid", '0, o_lane_valid);
    check_val("o_halt", '0, o_halt);
    check_val("o_raw_hazard", '0, o_raw_hazard);
  endtask

  task automatic compare_packet(input pkt_rec_t r);
    logic [2*LANES:0] fl;
    logic [LANES-1:0] vld;
    logic [LANES-1:0] ill;
    lane_dec_t        dec[LANES];
    fl  = packet_flags(r.v, r.pkt);
    vld = fl[LANES-1:0];
    ill = '0;
    for (int k = 0; k < LANES; k++) begin
      dec[k] = decode_word(r.pkt[k*32 +: 32]);
      ill[k] = vld[k] & dec[k].illegal;
    end
    check_val("o_lane_valid", vld, o_lane_valid);
    check_val("o_raw_hazard", fl[2*LANES-1:LANES], o_raw_hazard);
    check_val("o_halt", fl[2*LANES], o_halt);
    check_val("o_illegal", ill, o_illegal);
    for (int k = 0; k < LANES; k++) begin
      if (vld[k]) begin  // payload of masked lanes is don't care
        check_val($sformatf("o_pc[%0d]", k), r.pc + 4 * k, o_pc[k*XLEN +: XLEN]);
        check_val($sformatf("o_imm[%0d]", k), dec[k].imm, o_imm[k*XLEN +: XLEN]);
        check_val($sformatf("o_rd[%0d]", k), dec[k].rd, o_rd[k*5 +: 5]);
        check_val($sformatf("o_ra[%0d]", k), dec[k].ra, o_ra[k*5 +: 5]);
        check_val($sformatf("o_rb[%0d]", k), dec[k].rb, o_rb[k*5 +: 5]);
        check_val($sformatf("o_reg_wr[%0d]", k), dec[k].reg_wr, o_reg_wr[k]);
        check_val($sformatf("o_alu_a_src[%0d]", k), dec[k].alu_a_src, o_alu_a_src[k]);
        check_val($sformatf("o_alu_b_src[%0d]", k), dec[k].alu_b_src,
                  o_alu_b_src[k*ALU_B_SRC_W +: ALU_B_SRC_W]);
        check_val($sformatf("o_alu_ctr[%0d]", k), dec[k].alu_ctr,
                  o_alu_ctr[k*ALU_CTR_W +: ALU_CTR_W]);
        check_val($sformatf("o_pc_a_src[%0d]", k), dec[k].pc_a_src, o_pc_a_src[k]);
        check_val($sformatf("o_pc_b_src[%0d]", k), dec[k].pc_b_src, o_pc_b_src[k]);
        check_val($sformatf("o_mem_to_reg[%0d]", k), dec[k].mem_to_reg, o_mem_to_reg[k]);
        check_val($sformatf("o_mem_wr[%0d]", k), dec[k].mem_wr, o_mem_wr[k]);
        check_val($sformatf("o_mem_op[%0d]", k), dec[k].mem_op,
                  o_mem_op[k*MEM_OP_W +: MEM_OP_W]);
      end
    end
  endtask

  // one cycle that checks the packet from two cycles back and drives the next one
  task automatic step(input logic v, input logic [XLEN-1:0] pc, input logic [LANES*32-1:0] pkt);
    pkt_rec_t r;
    @(posedge i_clk);
    #2;
    if (sent_q.size() == 2) compare_packet(sent_q.pop_front());
    i_valid  = v;
    i_pc     = pc;
    i_packet = pkt;
    r.v      = v;
    r.pc     = pc;
    r.pkt    = pkt;
    sent_q.push_back(r);
  endtask

  task automatic flush();
    repeat (2) step(1'b0, '0, '0);
  endtask

  function automatic logic random_valid();
    return ({$random(seed)} % 10) < 8;
  endfunction

  function automatic logic [XLEN-1:0] random_pc();
    logic [XLEN-1:0] pc;
    pc = {$random(seed), $random(seed)};
    pc[1:0] = 2'b00;
    return pc;
  endfunction

  // small register pool including x0 so that lanes collide often
  function automatic logic [31:0] random_inst();
    logic [31:0] w;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    int          sel;
    w   = $random(seed);
    rd  = 5'({$random(seed)} % 4);
    rs1 = 5'({$random(seed)} % 4);
    rs2 = 5'({$random(seed)} % 4);
    sel = {$random(seed)} % 14;
    case (sel)
      0: w = {w[31:12], rd, OP_LUI};
      1: w = {w[31:12], rd, OP_AUIPC};
      2: w = {w[31:12], rd, OP_JAL};
      3: w = {w[31:20], rs1, F3_ZERO, rd, OP_JALR};
      4: w = {w[31:20], rs1, F3_W, rd, OP_LOAD};
      5: w = {w[31:20], rs1, F3_ZERO, rd, OP_IMM};
      6: w = {w[31:25], rs2, rs1, F3_W, w[11:7], OP_STORE};
      7: w = {w[31:25], rs2, rs1, F3_D, w[11:7], OP_STORE};
      8: w = EBREAK;
      default: ;  // raw word that is mostly illegal
    endcase
    return w;
  endfunction

  function automatic logic [LANES*32-1:0] random_packet();
    logic [LANES*32-1:0] p;
    for (int k = 0; k < LANES; k++) p[k*32 +: 32] = random_inst();
    return p;
  endfunction

  function automatic logic [31:0] addi_word(input logic [4:0] rd, input logic [4:0] rs1);
    return {12'h01c, rs1, F3_ZERO, rd, OP_IMM};
  endfunction

  task automatic run_reset();
    for (int c = 0; c < RST_CYCLES; c++) begin
      @(posedge i_clk);
      #2;
      check_idle();
      i_valid  = random_valid();  // inputs toggle freely under reset
      i_pc     = random_pc();
      i_packet = random_packet();
    end
    i_rst_n = 1'b1;
    i_valid = 1'b0;
    repeat (2) begin
      @(posedge i_clk);
      #2;
      check_idle();
    end
  endtask

  task automatic run_random();
    logic                v;
    logic [XLEN-1:0]     pc;
    logic [LANES*32-1:0] pkt;
    repeat (N_RANDOM) begin
      v   = random_valid();
      pc  = random_pc();
      pkt = random_packet();
      step(v, pc, pkt);
    end
    flush();
  endtask

  task automatic run_break();
    step(1'b1, random_pc(), {addi_word(5'd1, 5'd2), EBREAK});  // lane 1 masked
    step(1'b1, random_pc(), {EBREAK, addi_word(5'd1, 5'd2)});
    step(1'b1, random_pc(), {EBREAK, EBREAK});
    step(1'b0, random_pc(), {EBREAK, EBREAK});  // no halt without valid
    step(1'b1, random_pc(), {addi_word(5'd3, 5'd1), addi_word(5'd1, 5'd2)});
    flush();
  endtask

  task automatic run_hazard();
    step(1'b1, random_pc(), {addi_word(5'd3, 5'd1), addi_word(5'd1, 5'd0)});
    step(1'b1, random_pc(), {{7'h0, 5'd1, 5'd4, F3_W, 5'd0, OP_STORE}, addi_word(5'd1, 5'd2)});
    // writes to x0 never create a dependency
    step(1'b1, random_pc(), {addi_word(5'd2, 5'd0), addi_word(5'd0, 5'd5)});
    // system word writing x1 masks its reader
    step(1'b1, random_pc(), {addi_word(5'd2, 5'd1), {12'h001, 5'd0, F3_ZERO, 5'd1, OP_SYSTEM}});
    step(1'b1, random_pc(), {addi_word(5'd2, 5'd1), {7'h0, 5'd1, 5'd4, F3_D, 5'd1, OP_STORE}});
    flush();
  endtask

  task automatic finish_test(input string name);
    int errs;
    errs     = n_errors - err_mark;
    err_mark = n_errors;
    if (errs == 0)
      tests_passed++;
    else
      tests_failed++;
    $display("test %s finished with %0d errors", name, errs);
  endtask

  initial begin
    seed         = 32'hfcb2;
    n_checks     = 0;
    n_errors     = 0;
    err_mark     = 0;
    tests_passed = 0;
    tests_failed = 0;
    i_rst_n      = 1'b0;
    i_valid      = 1'b0;
    i_packet     = '0;
    i_pc         = '0;
    run_reset();
    finish_test("reset");
    run_random();
    finish_test("random decode stream");
    run_break();
    finish_test("ebreak masking and halt");
    run_hazard();
    finish_test("in-packet hazards");
    $display("tests passed %0d failed %0d, checks %0d errors %0d",
             tests_passed, tests_failed, n_checks, n_errors);
    if (tests_failed == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("timeout: the run did not finish within %0d ns", WATCHDOG_NS);
    $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

`default_nettype wire
